// ==== source/uart_pkg.sv ====
package uart_pkg;

    // ----------------------------------------
    // baud timing
    // ----------------------------------------
    localparam int CLK_DIV    = 4;              // cen cycles per tick
    localparam int BIT_TICKS  = 8;              // ticks per serial bit
    localparam int HALF_TICKS = BIT_TICKS / 2;  // start edge to start bit centre
    localparam int DATA_BITS  = 8;              // payload bits per frame

    localparam int DIV_W  = $clog2(CLK_DIV);    // tick divider width
    localparam int TICK_W = $clog2(BIT_TICKS);  // bit period countdown width
    localparam int BIT_W  = $clog2(DATA_BITS);  // data bit index width

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef logic [DATA_BITS-1:0] uart_byte_t;

    typedef enum logic [1:0] {
        RX_IDLE,   // waiting for falling edge
        RX_START,  // half bit to start bit centre
        RX_DATA,   // shifting in payload
        RX_STOP    // checking stop bit
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

// ==== source/uart_tick_gen.sv ====
`timescale 1ns/1ps

module uart_tick_gen (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,    // clock enable qualifies every count
    output logic tick    // one cycle every CLK_DIV enabled cycles
);
    import uart_pkg::*;

    // ----------------------------------------
    // free-running divider
    // ----------------------------------------
    logic [DIV_W-1:0] div_cnt;   // counts down to zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= DIV_W'(CLK_DIV - 1);
            tick    <= 1'b0;
        end else if (cen) begin
            if (div_cnt == '0) begin
                div_cnt <= DIV_W'(CLK_DIV - 1);   // reload
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt - 1'b1;
                tick    <= 1'b0;
            end
        end
        // cen low holds counter and tick
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 tick,      // oversampling tick
    input  logic                 uart_rx,   // raw serial line
    output uart_pkg::uart_byte_t rx_data,   // last good byte
    output logic                 rx_done,   // frame finished
    output logic                 rx_error   // bad stop bit
);
    import uart_pkg::*;

    // ----------------------------------------
    // input synchronizer
    // ----------------------------------------
    logic rx_meta;   // first stage
    logic rx_sync;   // safe to use

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;   // line idles high
            rx_sync <= 1'b1;
        end else if (cen) begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // ----------------------------------------
    // receive FSM
    // ----------------------------------------
    rx_state_e         state;
    logic [TICK_W-1:0] tick_cnt;    // ticks left to next sample
    logic [BIT_W-1:0]  bit_cnt;     // data bit index
    uart_byte_t        shift_reg;   // assembled payload
    logic              sample;      // sample point reached

    assign sample = tick && (tick_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_data  <= '0;
            rx_done  <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_done <= 1'b0;   // single clock pulse
            if (cen) begin
                // bit period countdown while busy
                if (state != RX_IDLE && tick) begin
                    tick_cnt <= sample ? TICK_W'(BIT_TICKS - 1) : tick_cnt - 1'b1;
                end
                case (state)
                    RX_IDLE: begin
                        if (!rx_sync) begin   // falling edge seen
                            state    <= RX_START;
                            tick_cnt <= TICK_W'(HALF_TICKS - 1);
                        end
                    end
                    RX_START: begin
                        if (sample) begin
                            if (rx_sync) begin
                                state <= RX_IDLE;   // line high again so only a glitch
                            end else begin
                                state   <= RX_DATA;
                                bit_cnt <= '0;
                            end
                        end
                    end
                    RX_DATA: begin
                        if (sample) begin
                            if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                                state <= RX_STOP;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    RX_STOP: begin
                        if (sample) begin
                            state   <= RX_IDLE;
                            rx_done <= 1'b1;
                            if (rx_sync) begin   // stop bit ok
                                rx_data  <= shift_reg;
                                rx_error <= 1'b0;
                            end else begin
                                rx_error <= 1'b1;   // framing error keeps old byte
                            end
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // lsb first so shift in from the top
    always_ff @(posedge clk) begin
        if (cen && sample && state == RX_DATA) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,
    input  logic                 tick,      // oversampling tick
    input  uart_pkg::uart_byte_t tx_data,   // byte to send
    input  logic                 tx_wr,     // write strobe
    output logic                 uart_tx,   // serial out, high when idle
    output logic                 tx_done    // end of stop bit
);
    import uart_pkg::*;

    // ----------------------------------------
    // transmit FSM
    // ----------------------------------------
    tx_state_e         state;
    logic [TICK_W-1:0] tick_cnt;    // ticks left in current bit
    logic [BIT_W-1:0]  bit_cnt;     // data bits already on the line
    uart_byte_t        shift_reg;   // bits still to send
    logic              bit_end;     // current bit period over

    assign bit_end = tick && (tick_cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            uart_tx  <= 1'b1;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;   // single clock pulse
            if (cen) begin
                if (tx_wr) begin   // restarts even mid frame
                    state    <= TX_START;
                    tick_cnt <= TICK_W'(BIT_TICKS - 1);
                    bit_cnt  <= '0;
                    uart_tx  <= 1'b0;   // start bit
                end else if (state != TX_IDLE && tick) begin
                    tick_cnt <= bit_end ? TICK_W'(BIT_TICKS - 1) : tick_cnt - 1'b1;
                    if (bit_end) begin
                        case (state)
                            TX_START: begin
                                state   <= TX_DATA;
                                uart_tx <= shift_reg[0];   // lsb first
                            end
                            TX_DATA: begin
                                if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                                    state   <= TX_STOP;
                                    uart_tx <= 1'b1;   // stop bit
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                    uart_tx <= shift_reg[0];
                                end
                            end
                            TX_STOP: begin
                                state   <= TX_IDLE;
                                tx_done <= 1'b1;
                            end
                            default: state <= TX_IDLE;
                        endcase
                    end
                end
            end
        end
    end

    // payload shifter
    always_ff @(posedge clk) begin
        if (cen) begin
            if (tx_wr) begin
                shift_reg <= tx_data;
            end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
                shift_reg <= {1'b0, shift_reg[DATA_BITS-1:1]};   // next bit to lsb
            end
        end
    end

endmodule

// ==== source/uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen,        // global clock enable
    // serial pins
    input  logic       uart_rx,
    output logic       uart_tx,
    // receive side
    output logic [7:0] rx_data,
    output logic       rx_done,
    output logic       rx_error,
    // transmit side
    input  logic [7:0] tx_data,
    input  logic       tx_wr,
    output logic       tx_done
);

    // ----------------------------------------
    // shared baud tick
    // ----------------------------------------
    logic tick;   // feeds both directions

    uart_tick_gen tick_gen_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .tick  (tick)
    );

    // ----------------------------------------
    // receiver
    // ----------------------------------------
    uart_rx rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .tick     (tick),
        .uart_rx  (uart_rx),
        .rx_data  (rx_data),
        .rx_done  (rx_done),
        .rx_error (rx_error)
    );

    // ----------------------------------------
    // transmitter
    // ----------------------------------------
    uart_tx tx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen     (cen),
        .tick    (tick),
        .tx_data (tx_data),
        .tx_wr   (tx_wr),
        .uart_tx (uart_tx),
        .tx_done (tx_done)
    );

endmodule

// ==== bench/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;
    import uart_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int BIT_CYC    = CLK_DIV * BIT_TICKS;        // cycles per serial bit
    localparam int FRAME_CYC  = (DATA_BITS + 2) * BIT_CYC;  // start + data + stop
    localparam int MAX_VEC    = 64;
    localparam int STALL_AT   = 3 * BIT_CYC + 5;            // lands inside data bit 2
    localparam int STALL_LEN  = 45;

    logic       clk;
    logic       rst_n;
    logic       cen;
    logic       uart_rx;
    logic       uart_tx;
    logic [7:0] rx_data;
    logic       rx_done;
    logic       rx_error;
    logic [7:0] tx_data;
    logic       tx_wr;
    logic       tx_done;

    logic [7:0] vec_op   [0:MAX_VEC-1];   // opcode letter
    uart_byte_t vec_val  [0:MAX_VEC-1];
    logic       vec_stop [0:MAX_VEC-1];
    int         vec_count      = 0;
    logic       vectors_loaded = 1'b0;

    int         mismatch_errors = 0;
    int         timeout_errors  = 0;
    int         other_errors    = 0;
    int         en_cycles   = 0;      // posedges with cen high
    int         rx_done_cnt = 0;
    int         tx_done_cnt = 0;
    int         tx_done_en  = 0;      // en_cycles at last tx_done
    uart_byte_t last_good   = '0;     // rx_data resets to zero

    uart_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx),
        .rx_data  (rx_data),
        .rx_done  (rx_done),
        .rx_error (rx_error),
        .tx_data  (tx_data),
        .tx_wr    (tx_wr),
        .tx_done  (tx_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // pulse counters read by the tasks on falling edges
    always @(posedge clk) begin
        if (cen === 1'b1) en_cycles <= en_cycles + 1;
        if (rx_done === 1'b1) rx_done_cnt <= rx_done_cnt + 1;
        if (tx_done === 1'b1) begin
            tx_done_cnt <= tx_done_cnt + 1;
            tx_done_en  <= en_cycles;
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task idle_gap;
        repeat (4 + $urandom % 28) @(negedge clk);
    endtask

    // ----------------------------------------
    // transmit side
    // ----------------------------------------
    task capture_tx_frame(output uart_byte_t data, output logic stop_bit, output int start_en);
        int waited;
        int k;
        waited   = 0;
        data     = '0;
        stop_bit = 1'b0;
        while (uart_tx !== 1'b0 && waited < 8) begin   // start edge follows tx_wr
            @(negedge clk);
            waited++;
        end
        start_en = en_cycles;
        if (uart_tx !== 1'b0) begin
            timeout_errors++;
            $display("timeout: uart_tx never went low after tx_wr at %0t", $time);
        end else begin
            for (k = 0; k <= DATA_BITS + 1; k++) begin
                while (en_cycles - start_en < BIT_CYC / 2 + k * BIT_CYC) @(negedge clk);
                if (k == 0) check_bit("uart_tx start bit", uart_tx, 1'b0);
                else if (k <= DATA_BITS) data[k-1] = uart_tx;   // lsb first
                else stop_bit = uart_tx;
            end
        end
    endtask

    task stall_cen;
        repeat (STALL_AT) @(negedge clk);
        cen = 1'b0;   // freezes tick and bit counters
        repeat (STALL_LEN) @(negedge clk);
        cen = 1'b1;
    endtask

    task send_tx_byte(input uart_byte_t value, input logic stop_exp, input logic stall);
        uart_byte_t got;
        logic       stop_bit;
        int         start_en;
        int         done0;
        int         waited;
        int         elapsed;
        done0   = tx_done_cnt;
        tx_data = value;
        tx_wr   = 1'b1;
        @(negedge clk);
        tx_wr = 1'b0;
        if (stall) begin
            fork
                capture_tx_frame(got, stop_bit, start_en);
                stall_cen();
            join
        end else begin
            capture_tx_frame(got, stop_bit, start_en);
        end
        check_byte("uart_tx data", got, value);
        check_bit("uart_tx stop bit", stop_bit, stop_exp);
        waited = 0;
        while (tx_done_cnt == done0 && waited < 2 * BIT_CYC) begin
            @(negedge clk);
            waited++;
        end
        if (tx_done_cnt == done0) begin
            timeout_errors++;
            $display("timeout: no tx_done after sending byte 0x%02h", value);
        end else begin
            // start bit is 7 to 8 ticks and the rest are whole bits
            elapsed = tx_done_en - start_en;
            if (elapsed < (BIT_TICKS - 1) * CLK_DIV + (DATA_BITS + 1) * BIT_CYC ||
                elapsed > FRAME_CYC) begin
                other_errors++;
                $display("tx_done came %0d enabled cycles after the start edge", elapsed);
            end
            repeat (4) @(negedge clk);
            if (tx_done_cnt != done0 + 1) begin
                other_errors++;
                $display("expected one tx_done pulse for byte 0x%02h", value);
            end
        end
    endtask

    // ----------------------------------------
    // receive side
    // ----------------------------------------
    task drive_rx_bit(input logic b);
        uart_rx = b;
        repeat (BIT_CYC) @(negedge clk);
    endtask

    task settle_after_bad_stop;
        int done0;
        done0 = rx_done_cnt;
        repeat (FRAME_CYC) @(negedge clk);
        // a low stop bit may pass for a start bit and the idle line then reads as ones
        if (rx_done_cnt != done0) begin
            if (rx_done_cnt != done0 + 1) begin
                other_errors++;
                $display("more than one rx_done after a bad stop bit");
            end
            last_good = 8'hff;
            check_bit("rx_error", rx_error, 1'b0);
            check_byte("rx_data", rx_data, last_good);
        end
    endtask

    task drive_rx_frame(input uart_byte_t value, input logic stop_val);
        int k;
        int done0;
        int waited;
        done0 = rx_done_cnt;
        drive_rx_bit(1'b0);
        for (k = 0; k < DATA_BITS; k++) drive_rx_bit(value[k]);
        drive_rx_bit(stop_val);
        uart_rx = 1'b1;
        waited  = 0;
        while (rx_done_cnt == done0 && waited < BIT_CYC) begin
            @(negedge clk);
            waited++;
        end
        if (rx_done_cnt == done0) begin
            timeout_errors++;
            $display("timeout: no rx_done for frame with byte 0x%02h", value);
        end else begin
            if (rx_done_cnt != done0 + 1) begin
                other_errors++;
                $display("expected one rx_done pulse for byte 0x%02h", value);
            end
            if (stop_val) last_good = value;   // bad stop keeps old byte
            check_bit("rx_error", rx_error, ~stop_val);
            check_byte("rx_data", rx_data, last_good);
            if (!stop_val) settle_after_bad_stop();
        end
    endtask

    task drive_glitch(input int len);
        int done0;
        done0   = rx_done_cnt;
        uart_rx = 1'b0;
        repeat (len) @(negedge clk);
        uart_rx = 1'b1;
        repeat (2 * FRAME_CYC) @(negedge clk);
        if (rx_done_cnt != done0) begin
            other_errors++;
            $display("a %0d cycle glitch on uart_rx produced rx_done", len);
        end
    endtask

    task load_vectors;
        int             fd;
        int             code;
        logic [7:0]     op_c;
        logic [7:0]     val;
        logic [7:0]     stp;
        logic [1023:0]  line_buf;
        fd = $fopen("bench/uart_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open bench/uart_vectors.txt");
        end else begin
            code = $fscanf(fd, " %c", op_c);
            while (code == 1 && vec_count < MAX_VEC) begin
                if (op_c == "#") begin
                    code = $fgets(line_buf, fd);   // rest of comment line
                end else if ($fscanf(fd, " %h %h", val, stp) != 2) begin
                    other_errors++;
                    $display("malformed vector line for opcode %c", op_c);
                end else begin
                    vec_op[vec_count]   = op_c;
                    vec_val[vec_count]  = val;
                    vec_stop[vec_count] = stp[0];
                    vec_count++;
                end
                code = $fscanf(fd, " %c", op_c);
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int i;
        int rng_seed;
        clk      = 1'b0;
        rst_n    = 1'b0;
        cen      = 1'b1;
        uart_rx  = 1'b1;   // idle line
        tx_data  = '0;
        tx_wr    = 1'b0;
        rng_seed = 92;
        void'($urandom(rng_seed));
        load_vectors();
        if (vec_count > 0) vectors_loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("uart_tx", uart_tx, 1'b1);
        check_bit("rx_done", rx_done, 1'b0);
        check_bit("tx_done", tx_done, 1'b0);
        check_bit("rx_error", rx_error, 1'b0);
        check_byte("rx_data", rx_data, 8'h00);
        for (i = 0; i < vec_count; i++) begin
            idle_gap();
            case (vec_op[i])
                "T": send_tx_byte(vec_val[i], vec_stop[i], 1'b0);
                "C": send_tx_byte(vec_val[i], vec_stop[i], 1'b1);
                "R": drive_rx_frame(vec_val[i], vec_stop[i]);
                "G": drive_glitch(vec_val[i]);
                default: begin
                    other_errors++;
                    $display("unknown opcode %c in vector %0d", vec_op[i], i);
                end
            endcase
        end
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_errors, timeout_errors, other_errors);
        if (mismatch_errors + timeout_errors + other_errors == 0 && vec_count > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // budget of 12 bit times per vector and then doubled
    initial begin
        wait (vectors_loaded === 1'b1);
        #(vec_count * 12 * BIT_CYC * CLK_PERIOD * 2);
        timeout_errors++;
        $display("watchdog expired before all %0d vectors finished", vec_count);
        $display("errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_errors, timeout_errors, other_errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
source/uart_pkg.sv
source/uart_tick_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_top.sv
bench/uart_tb.sv

// ==== bench/uart_vectors.txt ====
# op byte stop   T/C send byte on uart_tx (C holds cen low mid frame), stop = expected stop bit
# R drives byte on uart_rx with the given stop bit, G is a low glitch of byte cycles (hex)
# all fields hex
T a5 1
T 00 1
T ff 1
T 3c 1
R 5a 1
R 01 1
R 80 1
R c3 0
R 7e 1
G 05 1
R 96 1
G 0b 1
R 0f 1
G 01 1
T 81 1
C 6d 1
C f0 1
R e7 1
R 24 0
R 42 1
T 55 1
T aa 1
G 08 1
R 99 1
C 12 1
T fe 1
R 33 1
